//--- Makefile
SIM := obj_dir/Vcore_mem_subsys_tb

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard logic/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert -f sources.f --top-module core_mem_subsys_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/core_mem_subsys_checker.sv
// Bridge AXI4-Lite channel checks
`timescale 1ns/1ps
`include "bus_config.svh"

module core_mem_subsys_checker (
  input logic                       i_aclk,
  input logic                       i_rst_n,
  input logic                       i_awvalid,
  input logic                       i_awready,
  input logic [`BUS_ADDR_WIDTH-1:0] i_awaddr,
  input logic                       i_wvalid,
  input logic                       i_wready,
  input logic [`BUS_DATA_WIDTH-1:0] i_wdata,
  input logic [`BUS_STRB_WIDTH-1:0] i_wstrb,
  input logic                       i_bvalid,
  input logic                       i_bready,
  input logic                       i_arvalid,
  input logic                       i_arready,
  input logic [`BUS_ADDR_WIDTH-1:0] i_araddr,
  input logic                       i_rvalid,
  input logic                       i_rready,
  input logic [`BUS_DATA_WIDTH-1:0] i_rdata,
  input logic                       i_rw_ready
);

  // ------------------------------------------------------------
  // Valid and payload held until the handshake
  // ------------------------------------------------------------
  aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else $error("AW valid or address dropped before handshake");

  w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else $error("W valid or payload dropped before handshake");

  b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid)
    else $error("B valid dropped before handshake");

  ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else $error("AR valid or address dropped before handshake");

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else $error("R valid or data dropped before handshake");

  // One address channel at a time
  ar_aw_excl: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_arvalid && i_awvalid))
    else $error("AR and AW valid in the same cycle");

  ready_pulse: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rw_ready |=> !i_rw_ready)
    else $error("Bridge ready longer than one cycle");

endmodule

//--- dv/core_mem_subsys_tb.sv
// Memory subsystem testbench
`timescale 1ns/1ps
`include "bus_config.svh"

module core_mem_subsys_tb
  import axi_pkg::*;
  import core_bus_pkg::*;
();

  localparam logic [31:0] OOR_BASE = 32'(8 * `SRAM_DEPTH); // First byte past the SRAM
  localparam int N_INIT = 32;
  localparam int N_WR   = 16;
  localparam int N_PAIR = 6;
  localparam int N_MIX  = 60;
  localparam int N_REQ  = N_INIT + 2 * N_WR + 2 + 2 * N_PAIR + 4 + 2 * N_MIX;
  localparam int TIMEOUT_CYCLES = N_REQ * 20;

  logic                         i_aclk;
  logic                         i_rst_n;
  logic                         i_if_valid;
  logic [`BUS_ADDR_WIDTH-1:0]   i_if_addr;
  logic [`BUS_DATA_WIDTH/2-1:0] o_if_instr;
  logic                         o_if_ready;
  logic                         o_if_err;
  logic                         i_ls_valid;
  logic                         i_ls_wen;
  logic [`BUS_ADDR_WIDTH-1:0]   i_ls_addr;
  logic [`BUS_DATA_WIDTH-1:0]   i_ls_wdata;
  logic [`BUS_STRB_WIDTH-1:0]   i_ls_wstrb;
  logic [`BUS_DATA_WIDTH-1:0]   o_ls_rdata;
  logic                         o_ls_ready;
  logic                         o_ls_err;

  logic [63:0] ref_mem [logic [31:0]]; // Doubleword index to contents
  int errors, checks, cycles;
  int if_done_cnt, ls_done_cnt;
  int if_streak, ls_streak;

  // Last completed result per port, expected to hold until the next one
  logic [63:0] ls_hold_data;
  logic [31:0] if_hold_instr;
  logic        ls_hold_err, if_hold_err;
  logic        ls_hold_rd;
  logic        ls_held, if_held;

  core_mem_subsys i_core_mem_subsys (.*);

  bind axil_master_bridge core_mem_subsys_checker u_checker (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .i_awaddr   (o_awaddr),
    .i_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_wdata    (o_wdata),
    .i_wstrb    (o_wstrb),
    .i_bvalid   (i_bvalid),
    .i_bready   (o_bready),
    .i_arvalid  (o_arvalid),
    .i_arready  (i_arready),
    .i_araddr   (o_araddr),
    .i_rvalid   (i_rvalid),
    .i_rready   (o_rready),
    .i_rdata    (i_rdata),
    .i_rw_ready (o_rw_ready)
  );

  initial begin
    i_aclk = 1'b0;
    forever #20 i_aclk = ~i_aclk;
  end

  // ------------------------------------------------------------
  // Reference memory model
  // ------------------------------------------------------------
  function automatic axil_resp_t ref_read(input logic [31:0] addr, output logic [63:0] data);
    data = '0;
    if (addr >= OOR_BASE) return RESP_SLVERR; // Past the end reads as zero
    if (ref_mem.exists(addr >> 3)) data = ref_mem[addr >> 3];
    return RESP_OKAY;
  endfunction

  function automatic axil_resp_t merge_write(input logic [31:0] addr, input logic [63:0] data,
                                             input logic [7:0] strb);
    logic [63:0] word;
    if (addr >= OOR_BASE) return RESP_SLVERR;
    word = ref_mem.exists(addr >> 3) ? ref_mem[addr >> 3] : '0;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    ref_mem[addr >> 3] = word;
    return RESP_OKAY;
  endfunction

  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'hA5A5_5A5A, ~addr};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  // Requester drivers called 2 ns after a rising edge
  task automatic ls_access(input logic wen, input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    i_ls_valid = 1'b1;
    i_ls_wen   = wen;
    i_ls_addr  = addr;
    i_ls_wdata = data;
    i_ls_wstrb = strb;
    do begin
      @(negedge i_aclk);
    end while (!o_ls_ready);
    @(posedge i_aclk);
    #2;
    i_ls_valid = 1'b0;
  endtask

  task automatic fetch(input logic [31:0] addr);
    i_if_valid = 1'b1;
    i_if_addr  = addr;
    do begin
      @(negedge i_aclk);
    end while (!o_if_ready);
    @(posedge i_aclk);
    #2;
    i_if_valid = 1'b0;
  endtask

  task automatic random_ls_op(input logic allow_oor);
    logic [31:0] addr;
    addr = 32'($urandom_range(0, N_INIT - 1)) << 3;
    if (allow_oor && $urandom_range(0, 7) == 0) addr = OOR_BASE + addr;
    ls_access(1'($urandom_range(0, 1)), addr, {$urandom, $urandom}, 8'($urandom));
  endtask

  task automatic random_fetch();
    fetch(32'($urandom_range(0, 2 * N_INIT - 1)) << 2);
  endtask

  task automatic idle_gap();
    int n;
    n = int'($urandom_range(0, 2));
    if (n > 0) begin
      repeat (n) @(posedge i_aclk);
      #2;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: done, %0d errors", name, errors - errs_before);
  endtask

  // ------------------------------------------------------------
  // Compare at the falling edge while the driver holds the command
  // ------------------------------------------------------------
  always @(negedge i_aclk) begin : compare
    logic [63:0] exp_d;
    axil_resp_t  exp_r;
    dword_u      word;
    if (i_rst_n) begin
      if (o_ls_ready) begin
        ls_done_cnt++;
        checks++;
        if (i_ls_wen) begin
          exp_r = merge_write(i_ls_addr, i_ls_wdata, i_ls_wstrb);
        end else begin
          exp_r = ref_read(i_ls_addr, exp_d);
          if (o_ls_rdata !== exp_d) report_mismatch("o_ls_rdata", o_ls_rdata, exp_d);
        end
        if (o_ls_err !== (exp_r != RESP_OKAY)) begin
          report_mismatch("o_ls_err", 64'(o_ls_err), 64'(exp_r != RESP_OKAY));
        end
        ls_held      = 1'b1;
        ls_hold_rd   = !i_ls_wen;
        ls_hold_data = exp_d;
        ls_hold_err  = (exp_r != RESP_OKAY);
        ls_streak = i_if_valid ? ls_streak + 1 : 0;
        if_streak = 0;
        if (ls_streak > 1) begin
          $display("** Error at %0t: load/store served twice while fetch waited", $time);
          errors++;
        end
      end else if (ls_held) begin
        if (o_ls_err !== ls_hold_err) begin
          report_mismatch("o_ls_err", 64'(o_ls_err), 64'(ls_hold_err));
        end
        if (ls_hold_rd && o_ls_rdata !== ls_hold_data) begin
          report_mismatch("o_ls_rdata", o_ls_rdata, ls_hold_data);
        end
      end
      if (o_if_ready) begin
        if_done_cnt++;
        checks++;
        exp_r = ref_read({i_if_addr[31:3], 3'b000}, exp_d);
        word.dword = exp_d;
        if (o_if_instr !== word.instr[i_if_addr[2]]) begin
          report_mismatch("o_if_instr", 64'(o_if_instr), 64'(word.instr[i_if_addr[2]]));
        end
        if (o_if_err !== (exp_r != RESP_OKAY)) begin
          report_mismatch("o_if_err", 64'(o_if_err), 64'(exp_r != RESP_OKAY));
        end
        if_held       = 1'b1;
        if_hold_instr = word.instr[i_if_addr[2]];
        if_hold_err   = (exp_r != RESP_OKAY);
        if_streak = i_ls_valid ? if_streak + 1 : 0;
        ls_streak = 0;
        if (if_streak > 1) begin
          $display("** Error at %0t: fetch served twice while load/store waited", $time);
          errors++;
        end
      end else if (if_held) begin
        if (o_if_instr !== if_hold_instr) begin
          report_mismatch("o_if_instr", 64'(o_if_instr), 64'(if_hold_instr));
        end
        if (o_if_err !== if_hold_err) begin
          report_mismatch("o_if_err", 64'(o_if_err), 64'(if_hold_err));
        end
      end
      if (!i_if_valid) ls_streak = 0;
      if (!i_ls_valid) if_streak = 0;
    end
  end

  always @(posedge i_aclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a request never got its ready pulse", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin : main
    int errs;
    int if_base, ls_base;
    logic [31:0] addr;
    void'($urandom(52488));
    ls_held    = 1'b0;
    if_held    = 1'b0;
    i_rst_n    = 1'b0;
    i_if_valid = 1'b0;
    i_if_addr  = '0;
    i_ls_valid = 1'b0;
    i_ls_wen   = 1'b0;
    i_ls_addr  = '0;
    i_ls_wdata = '0;
    i_ls_wstrb = '0;
    repeat (4) @(posedge i_aclk);
    #2;
    i_rst_n = 1'b1;

    errs = errors;
    for (int i = 0; i < N_INIT; i++) begin
      ls_access(1'b1, 32'(i) << 3, fill_word(32'(i) << 3), 8'hFF);
    end
    report_test("fill", errs);

    errs = errors;
    for (int i = 0; i < N_WR; i++) begin
      addr = 32'($urandom_range(0, N_INIT - 1)) << 3;
      ls_access(1'b1, addr, {$urandom, $urandom}, 8'($urandom));
      ls_access(1'b0, addr, '0, '0);
    end
    report_test("strobed write and read back", errs);

    errs = errors;
    fetch(32'h18); // Lower instruction
    fetch(32'h1C);
    report_test("fetch halves", errs);

    errs    = errors;
    if_base = if_done_cnt;
    ls_base = ls_done_cnt;
    fork
      for (int i = 0; i < N_PAIR; i++) random_ls_op(1'b0);
      for (int i = 0; i < N_PAIR; i++) random_fetch();
    join
    if (if_done_cnt - if_base != N_PAIR || ls_done_cnt - ls_base != N_PAIR) begin
      $display("** Error at %0t: contending ports did not all complete", $time);
      errors++;
    end
    report_test("contention", errs);

    errs = errors;
    ls_access(1'b1, OOR_BASE + 32'h28, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF);
    ls_access(1'b0, OOR_BASE + 32'h28, '0, '0);
    fetch(OOR_BASE + 32'h4);
    ls_access(1'b0, 32'h28, '0, '0); // Aliased index must be intact
    report_test("out of range", errs);

    errs = errors;
    fork
      for (int i = 0; i < N_MIX; i++) begin
        random_ls_op(1'b1);
        idle_gap();
      end
      for (int i = 0; i < N_MIX; i++) begin
        random_fetch();
        idle_gap();
      end
    join
    report_test("random mix", errs);

    $display("checks %0d, errors %0d, fetches %0d, load/stores %0d",
             checks, errors, if_done_cnt, ls_done_cnt);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- include/bus_config.svh
// Memory bus configuration
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Bus widths
`define BUS_DATA_WIDTH 64
`define BUS_ADDR_WIDTH 32
`define BUS_STRB_WIDTH 8 // One strobe per data byte

// Number of doublewords in the on-chip SRAM
`define SRAM_DEPTH 256

// Port that wins the first tie after reset (0 is fetch)
`define ARB_PRIO_RESET 1'b0

`endif

//--- logic/axi_pkg.sv
// AXI4-Lite response types
package axi_pkg;

  // ------------------------------------------------------------
  // Response codes on the B and R channels
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00, // Normal access done
    RESP_SLVERR = 2'b10  // Slave rejected the access
  } axil_resp_t;

endpackage

//--- logic/axil_master_bridge.sv
// AXI4-Lite master bridge
`timescale 1ns/1ps
`include "bus_config.svh"

module axil_master_bridge
  import axi_pkg::*;
(
  input  logic                       i_aclk,
  input  logic                       i_rst_n,

  // Strobe request side
  input  logic                       i_rw_valid,
  input  logic                       i_rw_wen,
  input  logic [`BUS_ADDR_WIDTH-1:0] i_rw_addr,
  input  logic [`BUS_DATA_WIDTH-1:0] i_rw_wdata,
  input  logic [`BUS_STRB_WIDTH-1:0] i_rw_wstrb,
  output logic                       o_rw_ready,
  output logic [`BUS_DATA_WIDTH-1:0] o_rw_rdata,
  output logic                       o_rw_err,

  // Write address channel
  output logic                       o_awvalid,
  input  logic                       i_awready,
  output logic [`BUS_ADDR_WIDTH-1:0] o_awaddr,

  // Write data channel
  output logic                       o_wvalid,
  input  logic                       i_wready,
  output logic [`BUS_DATA_WIDTH-1:0] o_wdata,
  output logic [`BUS_STRB_WIDTH-1:0] o_wstrb,

  // Write response channel
  input  logic                       i_bvalid,
  output logic                       o_bready,
  input  axil_resp_t                 i_bresp,

  // Read address channel
  output logic                       o_arvalid,
  input  logic                       i_arready,
  output logic [`BUS_ADDR_WIDTH-1:0] o_araddr,

  // Read data channel
  input  logic                       i_rvalid,
  output logic                       o_rready,
  input  logic [`BUS_DATA_WIDTH-1:0] i_rdata,
  input  axil_resp_t                 i_rresp
);

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_READ} rd_state_t;
  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

  rd_state_t rd_state_q, rd_state_d;
  wr_state_t wr_state_q, wr_state_d;
  logic      start;
  logic      aw_fire, w_fire, b_fire, ar_fire, r_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = i_bvalid  & o_bready;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid  & o_rready;

  // Requester still holds valid in the ready cycle, so skip it
  assign start = i_rw_valid & ~o_rw_ready & (rd_state_q == RD_IDLE) &
                 (wr_state_q == WR_IDLE);

  // ------------------------------------------------------------
  // Read and write FSMs
  // ------------------------------------------------------------
  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (start && !i_rw_wen) rd_state_d = RD_ADDR;
      RD_ADDR: if (ar_fire) rd_state_d = RD_READ;
      RD_READ: if (r_fire) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE: if (start && i_rw_wen) wr_state_d = WR_ADDR;
      WR_ADDR: if (aw_fire) wr_state_d = WR_DATA; // Address before data
      WR_DATA: if (w_fire) wr_state_d = WR_RESP;
      WR_RESP: if (b_fire) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state_q <= RD_IDLE;
      wr_state_q <= WR_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
      wr_state_q <= wr_state_d;
    end
  end

  // Channel outputs straight from state, payload from the held command
  assign o_arvalid = (rd_state_q == RD_ADDR);
  assign o_araddr  = i_rw_addr;
  assign o_rready  = (rd_state_q == RD_READ);
  assign o_awvalid = (wr_state_q == WR_ADDR);
  assign o_awaddr  = i_rw_addr;
  assign o_wvalid  = (wr_state_q == WR_DATA);
  assign o_wdata   = i_rw_wdata;
  assign o_wstrb   = i_rw_wstrb;
  assign o_bready  = (wr_state_q == WR_RESP);

  // ------------------------------------------------------------
  // Completion, one cycle after the R or B handshake
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rw_ready <= 1'b0;
      o_rw_err   <= 1'b0;
    end else begin
      o_rw_ready <= r_fire | b_fire;
      if (r_fire) begin
        o_rw_err <= (i_rresp != RESP_OKAY);
      end else if (b_fire) begin
        o_rw_err <= (i_bresp != RESP_OKAY);
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      o_rw_rdata <= i_rdata;
    end else if (b_fire) begin
      o_rw_rdata <= '0; // Writes return no data
    end
  end

endmodule

//--- logic/axil_sram.sv
// AXI4-Lite SRAM slave
`timescale 1ns/1ps
`include "bus_config.svh"

module axil_sram
  import axi_pkg::*;
(
  input  logic                       i_aclk,
  input  logic                       i_rst_n,

  // Write address channel
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  logic [`BUS_ADDR_WIDTH-1:0] i_awaddr,

  // Write data channel
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  logic [`BUS_DATA_WIDTH-1:0] i_wdata,
  input  logic [`BUS_STRB_WIDTH-1:0] i_wstrb,

  // Write response channel
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output axil_resp_t                 o_bresp,

  // Read address channel
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  logic [`BUS_ADDR_WIDTH-1:0] i_araddr,

  // Read data channel
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output logic [`BUS_DATA_WIDTH-1:0] o_rdata,
  output axil_resp_t                 o_rresp
);

  localparam int unsigned ADDR_W = `BUS_ADDR_WIDTH;
  localparam int IDX_W = $clog2(`SRAM_DEPTH);
  localparam int OFS_W = $clog2(`BUS_STRB_WIDTH);
  localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(`BUS_STRB_WIDTH * `SRAM_DEPTH);

  typedef enum logic [1:0] {S_IDLE, S_WDATA, S_BRESP, S_RDATA} state_t;

  state_t     state_q;
  axil_resp_t rresp_q, bresp_q;
  logic [ADDR_W-1:0]          waddr_q;
  logic [`BUS_DATA_WIDTH-1:0] rdata_q;
  logic [`BUS_DATA_WIDTH-1:0] mem [`SRAM_DEPTH];
  logic [IDX_W-1:0]           ridx, widx;
  logic ar_fire, aw_fire, w_fire;
  logic ar_ok, w_ok;

  // Read wins if both addresses arrive together
  assign o_arready = (state_q == S_IDLE);
  assign o_awready = (state_q == S_IDLE) & ~i_arvalid;
  assign o_wready  = (state_q == S_WDATA);
  assign o_bvalid  = (state_q == S_BRESP);
  assign o_rvalid  = (state_q == S_RDATA);

  assign ar_fire = i_arvalid & o_arready;
  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;

  // Range check against the SRAM size in bytes
  assign ar_ok = (i_araddr < MEM_BYTES);
  assign w_ok  = (waddr_q < MEM_BYTES);
  assign ridx  = i_araddr[OFS_W +: IDX_W];
  assign widx  = waddr_q[OFS_W +: IDX_W];

  // ------------------------------------------------------------
  // Slave FSM, one transaction at a time
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
      rresp_q <= RESP_OKAY;
      bresp_q <= RESP_OKAY;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ar_fire) begin
            state_q <= S_RDATA;
            rresp_q <= ar_ok ? RESP_OKAY : RESP_SLVERR;
          end else if (aw_fire) begin
            state_q <= S_WDATA;
          end
        end
        S_WDATA: begin
          if (w_fire) begin
            state_q <= S_BRESP;
            bresp_q <= w_ok ? RESP_OKAY : RESP_SLVERR;
          end
        end
        S_BRESP: if (i_bready) state_q <= S_IDLE; // Held until taken
        S_RDATA: if (i_rready) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Storage and read data
  always_ff @(posedge i_aclk) begin
    if (aw_fire) waddr_q <= i_awaddr;
    if (ar_fire) rdata_q <= ar_ok ? mem[ridx] : '0;
    if (w_fire && w_ok) begin
      for (int b = 0; b < `BUS_STRB_WIDTH; b++) begin
        if (i_wstrb[b]) mem[widx][8*b +: 8] <= i_wdata[8*b +: 8];
      end
    end
  end

  assign o_rdata = rdata_q;
  assign o_rresp = rresp_q;
  assign o_bresp = bresp_q;

endmodule

//--- logic/core_bus_pkg.sv
// Core memory bus types
`include "bus_config.svh"

package core_bus_pkg;

  // Requester that owns the bridge
  typedef enum logic {
    SEL_FETCH = 1'b0,
    SEL_LSU   = 1'b1
  } req_sel_t;

  // ------------------------------------------------------------
  // One SRAM doubleword, seen whole or as two instructions
  // ------------------------------------------------------------
  typedef union packed {
    logic [`BUS_DATA_WIDTH-1:0]        dword;
    logic [1:0][`BUS_DATA_WIDTH/2-1:0] instr; // Index 1 is the upper word, addr[2] set
  } dword_u;

endpackage

//--- logic/core_mem_subsys.sv
// Core memory subsystem top
`timescale 1ns/1ps
`include "bus_config.svh"

module core_mem_subsys
  import axi_pkg::*;
(
  input  logic                         i_aclk,
  input  logic                         i_rst_n,

  // Instruction fetch port
  input  logic                         i_if_valid,
  input  logic [`BUS_ADDR_WIDTH-1:0]   i_if_addr,
  output logic [`BUS_DATA_WIDTH/2-1:0] o_if_instr,
  output logic                         o_if_ready,
  output logic                         o_if_err,

  // Load/store port
  input  logic                         i_ls_valid,
  input  logic                         i_ls_wen,
  input  logic [`BUS_ADDR_WIDTH-1:0]   i_ls_addr,
  input  logic [`BUS_DATA_WIDTH-1:0]   i_ls_wdata,
  input  logic [`BUS_STRB_WIDTH-1:0]   i_ls_wstrb,
  output logic [`BUS_DATA_WIDTH-1:0]   o_ls_rdata,
  output logic                         o_ls_ready,
  output logic                         o_ls_err
);

  // ------------------------------------------------------------
  // Arbiter to bridge
  // ------------------------------------------------------------
  logic                       rw_valid, rw_wen, rw_ready, rw_err;
  logic [`BUS_ADDR_WIDTH-1:0] rw_addr;
  logic [`BUS_DATA_WIDTH-1:0] rw_wdata, rw_rdata;
  logic [`BUS_STRB_WIDTH-1:0] rw_wstrb;

  // Bridge to SRAM
  logic                       awvalid, awready, wvalid, wready, bvalid, bready;
  logic                       arvalid, arready, rvalid, rready;
  logic [`BUS_ADDR_WIDTH-1:0] awaddr, araddr;
  logic [`BUS_DATA_WIDTH-1:0] wdata, rdata;
  logic [`BUS_STRB_WIDTH-1:0] wstrb;
  axil_resp_t                 bresp, rresp;

  mem_port_arbiter u_arbiter (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_if_valid (i_if_valid),
    .i_if_addr  (i_if_addr),
    .o_if_instr (o_if_instr),
    .o_if_ready (o_if_ready),
    .o_if_err   (o_if_err),
    .i_ls_valid (i_ls_valid),
    .i_ls_wen   (i_ls_wen),
    .i_ls_addr  (i_ls_addr),
    .i_ls_wdata (i_ls_wdata),
    .i_ls_wstrb (i_ls_wstrb),
    .o_ls_rdata (o_ls_rdata),
    .o_ls_ready (o_ls_ready),
    .o_ls_err   (o_ls_err),
    .o_rw_valid (rw_valid),
    .o_rw_wen   (rw_wen),
    .o_rw_addr  (rw_addr),
    .o_rw_wdata (rw_wdata),
    .o_rw_wstrb (rw_wstrb),
    .i_rw_ready (rw_ready),
    .i_rw_rdata (rw_rdata),
    .i_rw_err   (rw_err)
  );

  axil_master_bridge u_bridge (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_rw_valid (rw_valid),
    .i_rw_wen   (rw_wen),
    .i_rw_addr  (rw_addr),
    .i_rw_wdata (rw_wdata),
    .i_rw_wstrb (rw_wstrb),
    .o_rw_ready (rw_ready),
    .o_rw_rdata (rw_rdata),
    .o_rw_err   (rw_err),
    .o_awvalid  (awvalid),
    .i_awready  (awready),
    .o_awaddr   (awaddr),
    .o_wvalid   (wvalid),
    .i_wready   (wready),
    .o_wdata    (wdata),
    .o_wstrb    (wstrb),
    .i_bvalid   (bvalid),
    .o_bready   (bready),
    .i_bresp    (bresp),
    .o_arvalid  (arvalid),
    .i_arready  (arready),
    .o_araddr   (araddr),
    .i_rvalid   (rvalid),
    .o_rready   (rready),
    .i_rdata    (rdata),
    .i_rresp    (rresp)
  );

  axil_sram u_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

endmodule

//--- logic/mem_port_arbiter.sv
// Fetch and load/store port arbiter
`timescale 1ns/1ps
`include "bus_config.svh"

module mem_port_arbiter
  import core_bus_pkg::*;
(
  input  logic                         i_aclk,
  input  logic                         i_rst_n,

  // Instruction fetch port, read only
  input  logic                         i_if_valid,
  input  logic [`BUS_ADDR_WIDTH-1:0]   i_if_addr,
  output logic [`BUS_DATA_WIDTH/2-1:0] o_if_instr,
  output logic                         o_if_ready,
  output logic                         o_if_err,

  // Load/store port
  input  logic                         i_ls_valid,
  input  logic                         i_ls_wen,
  input  logic [`BUS_ADDR_WIDTH-1:0]   i_ls_addr,
  input  logic [`BUS_DATA_WIDTH-1:0]   i_ls_wdata,
  input  logic [`BUS_STRB_WIDTH-1:0]   i_ls_wstrb,
  output logic [`BUS_DATA_WIDTH-1:0]   o_ls_rdata,
  output logic                         o_ls_ready,
  output logic                         o_ls_err,

  // Bridge side
  output logic                         o_rw_valid,
  output logic                         o_rw_wen,
  output logic [`BUS_ADDR_WIDTH-1:0]   o_rw_addr,
  output logic [`BUS_DATA_WIDTH-1:0]   o_rw_wdata,
  output logic [`BUS_STRB_WIDTH-1:0]   o_rw_wstrb,
  input  logic                         i_rw_ready,
  input  logic [`BUS_DATA_WIDTH-1:0]   i_rw_rdata,
  input  logic                         i_rw_err
);

  localparam int OFS_W = $clog2(`BUS_STRB_WIDTH);

  req_sel_t grant_q, prio_q, winner;
  logic     busy_q;
  logic     is_ls, if_done, ls_done;
  dword_u   rw_word;
  logic [`BUS_DATA_WIDTH/2-1:0] fetch_instr, if_instr_q;
  logic [`BUS_DATA_WIDTH-1:0]   ls_rdata_q;
  logic     if_err_q, ls_err_q;

  // Tie goes to the port named by the pointer
  always_comb begin
    if (i_if_valid && i_ls_valid) begin
      winner = prio_q;
    end else if (i_ls_valid) begin
      winner = SEL_LSU;
    end else begin
      winner = SEL_FETCH;
    end
  end

  // ------------------------------------------------------------
  // Grant lock, held until the bridge answers
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_q  <= 1'b0;
      grant_q <= SEL_FETCH;
      prio_q  <= req_sel_t'(`ARB_PRIO_RESET);
    end else if (!busy_q) begin
      if (i_if_valid || i_ls_valid) begin
        busy_q  <= 1'b1;
        grant_q <= winner;
        prio_q  <= (winner == SEL_FETCH) ? SEL_LSU : SEL_FETCH; // Other port next
      end
    end else if (i_rw_ready) begin
      busy_q <= 1'b0;
    end
  end

  assign is_ls      = (grant_q == SEL_LSU);
  assign o_rw_valid = busy_q;
  assign o_rw_wen   = is_ls & i_ls_wen;
  assign o_rw_addr  = is_ls ? i_ls_addr : {i_if_addr[`BUS_ADDR_WIDTH-1:OFS_W], {OFS_W{1'b0}}};
  assign o_rw_wdata = is_ls ? i_ls_wdata : '0;
  assign o_rw_wstrb = is_ls ? i_ls_wstrb : '0;

  // Return path
  assign rw_word     = i_rw_rdata;
  assign fetch_instr = rw_word.instr[i_if_addr[2]];
  assign if_done     = i_rw_ready & busy_q & ~is_ls;
  assign ls_done     = i_rw_ready & busy_q & is_ls;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      if_err_q <= 1'b0;
      ls_err_q <= 1'b0;
    end else begin
      if (if_done) if_err_q <= i_rw_err;
      if (ls_done) ls_err_q <= i_rw_err;
    end
  end

  // Hold each port's last result until its next completion
  always_ff @(posedge i_aclk) begin
    if (if_done) if_instr_q <= fetch_instr;
    if (ls_done) ls_rdata_q <= rw_word.dword;
  end

  assign o_if_ready = if_done;
  assign o_if_instr = if_done ? fetch_instr : if_instr_q;
  assign o_if_err   = if_done ? i_rw_err : if_err_q;
  assign o_ls_ready = ls_done;
  assign o_ls_rdata = ls_done ? rw_word.dword : ls_rdata_q;
  assign o_ls_err   = ls_done ? i_rw_err : ls_err_q;

endmodule

//--- sources.f
+incdir+include
logic/axi_pkg.sv
logic/core_bus_pkg.sv
logic/axil_master_bridge.sv
logic/mem_port_arbiter.sv
logic/axil_sram.sv
logic/core_mem_subsys.sv
dv/core_mem_subsys_checker.sv
dv/core_mem_subsys_tb.sv
